// File: design/issue_pkg.sv
package issue_pkg;

  localparam int inst_width = 32;

  // opcode field of an instruction word.
  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int opcode_width = opcode_msb - opcode_lsb + 1;

  // the top two opcode bits select the group.
  typedef enum logic [opcode_width-1:0] {
    op_nop   = 6'b000000,
    op_add   = 6'b000001,
    op_sub   = 6'b000010,
    op_cmp   = 6'b000011,
    op_test  = 6'b000100,
    op_addi  = 6'b010001,
    op_subi  = 6'b010010,
    op_cmpi  = 6'b010011,
    op_testi = 6'b010100,
    op_lw    = 6'b100000,
    op_sw    = 6'b100001,
    op_la    = 6'b100010,
    op_sa    = 6'b100011,
    op_jmp   = 6'b110000,
    op_jo    = 6'b110001,
    op_je    = 6'b110010
  } opcode_t;

  typedef enum logic [1:0] {
    class_dont_care = 2'b00,
    class_branch    = 2'b01,
    class_memory    = 2'b10
  } pipe_class_t;

  localparam logic [inst_width-1:0] nop_inst = '0;

  // pipe class of one instruction word.
  function automatic pipe_class_t classify(input logic [inst_width-1:0] inst);
    logic [opcode_width-1:0] op;
    pipe_class_t cls;
    op = inst[opcode_msb:opcode_lsb];
    case (op[opcode_width-1 -: 2])
      2'b00, 2'b01: begin // alu ops, flag setters go with the branch.
        if (op == op_cmp || op == op_test || op == op_cmpi || op == op_testi)
          cls = class_branch;
        else
          cls = class_dont_care;
      end
      2'b10: cls = class_memory;
      default: cls = class_branch;
    endcase
    return cls;
  endfunction

endpackage

// File: design/inst_rom.sv
`timescale 1ns/10ps

module inst_rom
  import issue_pkg::*;
#(
  parameter int addr_width = 6
) (
  input  logic [addr_width-1:0] pc,
  output logic [inst_width-1:0] inst0,
  output logic [inst_width-1:0] inst1
);

  localparam int depth = 2 ** addr_width;

  logic [inst_width-1:0] mem [0:depth-1];
  logic [addr_width-1:0] pc_plus1;

  initial begin
    $readmemh("program.hex", mem);
  end

  // wraps at the top of the rom.
  assign pc_plus1 = pc + addr_width'(1);

  assign inst0 = mem[pc];
  assign inst1 = mem[pc_plus1];

endmodule

// File: design/steer_unit.sv
`timescale 1ns/10ps

module steer_unit
  import issue_pkg::*;
#(
  parameter int addr_width = 6
) (
  input  logic [inst_width-1:0] inst0,
  input  logic [inst_width-1:0] inst1,
  input  logic [addr_width-1:0] pc,
  input  logic                  second_half,
  output logic [inst_width-1:0] slot_a_inst,
  output logic [inst_width-1:0] slot_b_inst,
  output logic [addr_width-1:0] slot_a_pc,
  output logic [addr_width-1:0] slot_b_pc,
  output logic                  split,
  output logic                  older_in_b
);

  pipe_class_t class0;
  pipe_class_t class1;
  logic [addr_width-1:0] pc0;
  logic [addr_width-1:0] pc1;

  assign class0 = classify(inst0);
  assign class1 = classify(inst1);

  assign pc0 = pc;
  assign pc1 = pc + addr_width'(1);

  always_comb begin
    case ({class0, class1})
      {class_branch, class_branch}: begin
        // one word per cycle into slot a.
        slot_b_inst = nop_inst;
        slot_b_pc   = '0;
        older_in_b  = 1'b0;
        if (!second_half) begin
          slot_a_inst = inst0;
          slot_a_pc   = pc0;
          split       = 1'b1;
        end else begin
          slot_a_inst = inst1;
          slot_a_pc   = pc1;
          split       = 1'b0;
        end
      end
      {class_memory, class_memory}: begin
        slot_a_inst = nop_inst;
        slot_a_pc   = '0;
        older_in_b  = 1'b1; // the live word sits in b.
        if (!second_half) begin
          slot_b_inst = inst0;
          slot_b_pc   = pc0;
          split       = 1'b1;
        end else begin
          slot_b_inst = inst1;
          slot_b_pc   = pc1;
          split       = 1'b0;
        end
      end
      {class_memory, class_branch}: begin
        slot_a_inst = inst1;
        slot_a_pc   = pc1;
        slot_b_inst = inst0;
        slot_b_pc   = pc0;
        split       = 1'b0;
        older_in_b  = 1'b1;
      end
      {class_memory, class_dont_care}: begin
        slot_a_inst = inst1;
        slot_a_pc   = pc1;
        slot_b_inst = inst0;
        slot_b_pc   = pc0;
        split       = 1'b0;
        older_in_b  = 1'b1;
      end
      {class_dont_care, class_branch}: begin
        slot_a_inst = inst1;
        slot_a_pc   = pc1;
        slot_b_inst = inst0;
        slot_b_pc   = pc0;
        split       = 1'b0;
        older_in_b  = 1'b1;
      end
      default: begin
        // already in program order.
        slot_a_inst = inst0;
        slot_a_pc   = pc0;
        slot_b_inst = inst1;
        slot_b_pc   = pc1;
        split       = 1'b0;
        older_in_b  = 1'b0;
      end
    endcase
  end

endmodule

// File: design/issue_ctrl.sv
`timescale 1ns/10ps

module issue_ctrl #(
  parameter int addr_width = 6,
  parameter int id_width   = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  stall,
  input  logic                  redirect,
  input  logic [addr_width-1:0] redirect_pc,
  input  logic                  split,
  output logic [addr_width-1:0] pc,
  output logic                  second_half,
  output logic                  issue_en,
  output logic                  flush,
  output logic [id_width-1:0]   cycle_count
);

  typedef enum logic {
    st_pair,
    st_second
  } state_t;

  state_t state;
  state_t state_next;

  // redirect wins over stall.
  assign issue_en    = !redirect && !stall;
  assign flush       = redirect;
  assign second_half = (state == st_second);

  always_comb begin
    state_next = state;
    if (redirect) begin
      state_next = st_pair;
    end else if (issue_en) begin
      if (split)
        state_next = st_second;
      else
        state_next = st_pair;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_pair;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (issue_en && !split) begin
      pc <= pc + addr_width'(2); // pair consumed.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle_count <= '0;
    end else if (issue_en) begin
      cycle_count <= cycle_count + id_width'(1);
    end
  end

endmodule

// File: design/issue_regs.sv
`timescale 1ns/10ps

module issue_regs
  import issue_pkg::*;
#(
  parameter int addr_width = 6,
  parameter int id_width   = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  issue_en,
  input  logic                  flush,
  input  logic [id_width-1:0]   cycle_count,
  input  logic [inst_width-1:0] slot_a_inst,
  input  logic [inst_width-1:0] slot_b_inst,
  input  logic [addr_width-1:0] slot_a_pc,
  input  logic [addr_width-1:0] slot_b_pc,
  input  logic                  older_in_b,
  output logic                  a_valid,
  output logic [inst_width-1:0] a_inst,
  output logic [addr_width-1:0] a_pc,
  output logic [id_width:0]     a_id,
  output logic                  b_valid,
  output logic [inst_width-1:0] b_inst,
  output logic [addr_width-1:0] b_pc,
  output logic [id_width:0]     b_id
);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      a_valid <= 1'b0;
      b_valid <= 1'b0;
    end else if (issue_en) begin
      a_valid <= (slot_a_inst != nop_inst);
      b_valid <= (slot_b_inst != nop_inst);
    end
  end

  // order bit 0 marks the older word.
  always_ff @(posedge clk) begin
    if (issue_en) begin
      a_inst <= slot_a_inst;
      a_pc   <= slot_a_pc;
      a_id   <= {cycle_count, older_in_b};
      b_inst <= slot_b_inst;
      b_pc   <= slot_b_pc;
      b_id   <= {cycle_count, !older_in_b};
    end
  end

endmodule

// File: design/dual_issue_top.sv
`timescale 1ns/10ps

module dual_issue_top
  import issue_pkg::*;
#(
  parameter int addr_width = 6,
  parameter int id_width   = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  stall,
  input  logic                  redirect,
  input  logic [addr_width-1:0] redirect_pc,
  output logic                  a_valid,
  output logic [inst_width-1:0] a_inst,
  output logic [addr_width-1:0] a_pc,
  output logic [id_width:0]     a_id,
  output logic                  b_valid,
  output logic [inst_width-1:0] b_inst,
  output logic [addr_width-1:0] b_pc,
  output logic [id_width:0]     b_id
);

  logic [addr_width-1:0] pc;
  logic                  second_half;
  logic                  issue_en;
  logic                  flush;
  logic [id_width-1:0]   cycle_count;
  logic [inst_width-1:0] inst0;
  logic [inst_width-1:0] inst1;
  logic [inst_width-1:0] slot_a_inst;
  logic [inst_width-1:0] slot_b_inst;
  logic [addr_width-1:0] slot_a_pc;
  logic [addr_width-1:0] slot_b_pc;
  logic                  split;
  logic                  older_in_b;

  issue_ctrl #(
    .addr_width (addr_width),
    .id_width   (id_width)
  ) issue_ctrl_i (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .split       (split),
    .pc          (pc),
    .second_half (second_half),
    .issue_en    (issue_en),
    .flush       (flush),
    .cycle_count (cycle_count)
  );

  inst_rom #(
    .addr_width (addr_width)
  ) inst_rom_i (
    .pc    (pc),
    .inst0 (inst0),
    .inst1 (inst1)
  );

  steer_unit #(
    .addr_width (addr_width)
  ) steer_unit_i (
    .inst0       (inst0),
    .inst1       (inst1),
    .pc          (pc),
    .second_half (second_half),
    .slot_a_inst (slot_a_inst),
    .slot_b_inst (slot_b_inst),
    .slot_a_pc   (slot_a_pc),
    .slot_b_pc   (slot_b_pc),
    .split       (split),
    .older_in_b  (older_in_b)
  );

  issue_regs #(
    .addr_width (addr_width),
    .id_width   (id_width)
  ) issue_regs_i (
    .clk         (clk),
    .reset       (reset),
    .issue_en    (issue_en),
    .flush       (flush),
    .cycle_count (cycle_count),
    .slot_a_inst (slot_a_inst),
    .slot_b_inst (slot_b_inst),
    .slot_a_pc   (slot_a_pc),
    .slot_b_pc   (slot_b_pc),
    .older_in_b  (older_in_b),
    .a_valid     (a_valid),
    .a_inst      (a_inst),
    .a_pc        (a_pc),
    .a_id        (a_id),
    .b_valid     (b_valid),
    .b_inst      (b_inst),
    .b_pc        (b_pc),
    .b_id        (b_id)
  );

endmodule

// File: sim/dual_issue_assert.sv
`timescale 1ns/10ps

module dual_issue_assert
  import issue_pkg::*;
#(
  parameter int addr_width = 6,
  parameter int id_width   = 8
) (
  input logic                  clk,
  input logic                  reset,
  input logic                  stall,
  input logic                  redirect,
  input logic                  issue_en,
  input logic                  second_half,
  input logic                  a_valid,
  input logic [inst_width-1:0] a_inst,
  input logic [addr_width-1:0] a_pc,
  input logic [id_width:0]     a_id,
  input logic                  b_valid,
  input logic [inst_width-1:0] b_inst,
  input logic [addr_width-1:0] b_pc,
  input logic [id_width:0]     b_id
);

  valid_low_after_reset: assert property (@(posedge clk)
    reset |=> !a_valid && !b_valid)
    else $error("valid output high after reset");

  // redirect overrides the stall.
  hold_under_stall: assert property (@(posedge clk) disable iff (reset)
    stall && !redirect |=> $stable({a_valid, a_inst, a_pc, a_id, b_valid, b_inst, b_pc, b_id}))
    else $error("issue outputs changed under stall");

  second_half_once: assert property (@(posedge clk) disable iff (reset)
    issue_en && second_half |=> !second_half)
    else $error("second half issued twice in a row");

endmodule

bind dual_issue_top dual_issue_assert #(
  .addr_width (addr_width),
  .id_width   (id_width)
) dual_issue_assert_i (
  .clk         (clk),
  .reset       (reset),
  .stall       (stall),
  .redirect    (redirect),
  .issue_en    (issue_en),
  .second_half (second_half),
  .a_valid     (a_valid),
  .a_inst      (a_inst),
  .a_pc        (a_pc),
  .a_id        (a_id),
  .b_valid     (b_valid),
  .b_inst      (b_inst),
  .b_pc        (b_pc),
  .b_id        (b_id)
);

// File: sim/tb_dual_issue.sv
`timescale 1ns/10ps

module tb_dual_issue
  import issue_pkg::*;
();

  localparam int addr_width = 6;
  localparam int id_width   = 8;
  localparam int depth      = 2 ** addr_width;
  localparam int run_cycles = 600;

  logic                  clk;
  logic                  reset;
  logic                  stall;
  logic                  redirect;
  logic [addr_width-1:0] redirect_pc;
  logic                  a_valid;
  logic [inst_width-1:0] a_inst;
  logic [addr_width-1:0] a_pc;
  logic [id_width:0]     a_id;
  logic                  b_valid;
  logic [inst_width-1:0] b_inst;
  logic [addr_width-1:0] b_pc;
  logic [id_width:0]     b_id;

  logic [inst_width-1:0] rom_ref [0:depth-1];

  // reference state and the slots it expects at the outputs.
  logic [addr_width-1:0] m_pc;
  logic                  m_second;
  logic [id_width-1:0]   m_count;
  logic                  issued;
  logic                  ref_split;
  logic                  ord_a;
  logic                  ord_b;
  logic                  exp_a_valid;
  logic                  exp_b_valid;
  logic [inst_width-1:0] exp_a_inst;
  logic [inst_width-1:0] exp_b_inst;
  logic [addr_width-1:0] exp_a_pc;
  logic [addr_width-1:0] exp_b_pc;
  logic [id_width:0]     exp_a_id;
  logic [id_width:0]     exp_b_id;
  logic                  check_en = 1'b0;
  logic                  passed = 1'b0;
  logic                  mismatch_seen = 1'b0;
  logic                  timed_out = 1'b0;

  dual_issue_top #(
    .addr_width (addr_width),
    .id_width   (id_width)
  ) dual_issue_top_i (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .a_valid     (a_valid),
    .a_inst      (a_inst),
    .a_pc        (a_pc),
    .a_id        (a_id),
    .b_valid     (b_valid),
    .b_inst      (b_inst),
    .b_pc        (b_pc),
    .b_id        (b_id)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic pipe_class_t class_of(input logic [inst_width-1:0] w);
    logic [5:0] op;
    op = w[31:26];
    if (op[5:4] == 2'b10)
      return class_memory;
    if (op[5:4] == 2'b11)
      return class_branch;
    if (op == op_cmp || op == op_test || op == op_cmpi || op == op_testi)
      return class_branch; // flag setters.
    return class_dont_care;
  endfunction

  // expected slot contents for the pair at pc.
  function automatic void steer_ref(
    input  logic [addr_width-1:0] pc,
    input  logic                  second,
    output logic [inst_width-1:0] a_w,
    output logic [addr_width-1:0] a_p,
    output logic                  a_ord,
    output logic [inst_width-1:0] b_w,
    output logic [addr_width-1:0] b_p,
    output logic                  b_ord,
    output logic                  split
  );
    logic [addr_width-1:0] pc1;
    logic [inst_width-1:0] w0;
    logic [inst_width-1:0] w1;
    pipe_class_t c0;
    pipe_class_t c1;
    pc1 = pc + addr_width'(1);
    w0 = rom_ref[pc];
    w1 = rom_ref[pc1];
    c0 = class_of(w0);
    c1 = class_of(w1);
    a_w = w0;
    a_p = pc;
    a_ord = 1'b0;
    b_w = w1;
    b_p = pc1;
    b_ord = 1'b1;
    split = 1'b0;
    if (c0 == c1 && c0 != class_dont_care) begin
      split = !second;
      if (c0 == class_branch) begin
        a_w = second ? w1 : w0;
        a_p = second ? pc1 : pc;
        b_w = '0;
        b_p = '0;
      end else begin
        b_w = second ? w1 : w0;
        b_p = second ? pc1 : pc;
        b_ord = 1'b0;
        a_w = '0;
        a_p = '0;
        a_ord = 1'b1;
      end
    end else if (c0 == class_memory || (c0 == class_dont_care && c1 == class_branch)) begin
      a_w = w1; // younger word goes to the branch slot.
      a_p = pc1;
      a_ord = 1'b1;
      b_w = w0;
      b_p = pc;
      b_ord = 1'b0;
    end
  endfunction

  task automatic mismatch_stop();
    mismatch_seen = 1'b1;
    $display("Test failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic inst_cmp(input string what, input logic [inst_width-1:0] got,
                          input logic [inst_width-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      mismatch_stop();
    end
  endtask

  task automatic pc_cmp(input string what, input logic [addr_width-1:0] got,
                        input logic [addr_width-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
      mismatch_stop();
    end
  endtask

  task automatic id_cmp(input string what, input logic [id_width:0] got,
                        input logic [id_width:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      mismatch_stop();
    end
  endtask

  task automatic valid_cmp(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
      mismatch_stop();
    end
  endtask

  // reads the inputs the dut sampled on this edge.
  always @(posedge clk) begin
    if (reset) begin
      m_pc = '0;
      m_second = 1'b0;
      m_count = '0;
      issued = 1'b0;
      exp_a_valid = 1'b0;
      exp_b_valid = 1'b0;
    end else if (redirect) begin
      m_pc = redirect_pc;
      m_second = 1'b0;
      exp_a_valid = 1'b0;
      exp_b_valid = 1'b0;
    end else if (!stall) begin
      steer_ref(m_pc, m_second, exp_a_inst, exp_a_pc, ord_a,
                exp_b_inst, exp_b_pc, ord_b, ref_split);
      exp_a_valid = (exp_a_inst != '0);
      exp_b_valid = (exp_b_inst != '0);
      exp_a_id = {m_count, ord_a};
      exp_b_id = {m_count, ord_b};
      m_count = m_count + id_width'(1);
      issued = 1'b1;
      m_second = ref_split;
      if (!ref_split)
        m_pc = m_pc + addr_width'(2);
    end
  end

  always @(negedge clk) begin
    if (check_en) begin
      valid_cmp("a_valid", a_valid, exp_a_valid);
      valid_cmp("b_valid", b_valid, exp_b_valid);
      if (issued) begin
        inst_cmp("a_inst", a_inst, exp_a_inst);
        inst_cmp("b_inst", b_inst, exp_b_inst);
        pc_cmp("a_pc", a_pc, exp_a_pc);
        pc_cmp("b_pc", b_pc, exp_b_pc);
        if (exp_a_valid)
          id_cmp("a_id", a_id, exp_a_id);
        if (exp_b_valid)
          id_cmp("b_id", b_id, exp_b_id);
      end
    end
  end

  task automatic wait_for_issue(input int limit);
    int n;
    n = 0;
    while (!(a_valid || b_valid) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!(a_valid || b_valid)) begin
      timed_out = 1'b1;
      $display("no valid issue slot within %0d cycles", limit);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  endtask

  initial begin
    void'($urandom(59667));
    $readmemh("program.hex", rom_ref);
    reset <= 1'b1;
    stall <= 1'b0;
    redirect <= 1'b0;
    redirect_pc <= '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    check_en = 1'b1;
    wait_for_issue(8);
    @(posedge clk); // hold a few cycles.
    stall <= 1'b1;
    repeat (4) @(posedge clk);
    stall <= 1'b0;
    @(posedge clk);
    redirect <= 1'b1;
    redirect_pc <= addr_width'(4); // a branch pair that splits.
    @(posedge clk);
    redirect <= 1'b0;
    @(negedge clk);
    wait_for_issue(8);
    for (int i = 0; i < run_cycles; i++) begin
      @(posedge clk);
      if ($urandom % 100 < 3) begin
        redirect <= 1'b1;
        redirect_pc <= addr_width'($urandom);
      end else begin
        redirect <= 1'b0;
      end
      stall <= ($urandom % 100 < 20);
    end
    @(posedge clk);
    redirect <= 1'b0;
    stall <= 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    passed = 1'b1;
    $display("Test completed successfully");
    $finish;
  end

  // an assertion can end the run early.
  final begin
    if (!passed && !mismatch_seen && !timed_out)
      $display("Test failed");
  end

endmodule

// File: program.hex
// four 32-bit instruction words per line, hex, starting at address 0.
// opcode in bits 31:26, pairs at even addresses cover every class pairing.
04221000 84430004 80650008 C800000C
0C812000 C0000010 80A60010 84A70014
44C80005 4CC90007 88EA0018 48EB0003
C4000020 8D0C001C 11221000 05231000
09442000 45450009 00000000 C0000030
80660000 00000000 00000000 00000000
4DA3000F 51A40002 8C270020 88280024
C8000008 80E90028 10A31000 C4000004
09C41000 85CA002C 0DC51000 49C60001
89CB0030 C0000002 51E70003 45E80004
05F21000 4DF30006 8DF40034 09F51000
C4000014 C800001C 80B60038 84B7003C
45090001 490A0002 00000000 8C2B0040
C0000000 00000000 0D2C1000 81330044
11341000 51350005 84360048 88370050
05381000 C8000018 80390054 C4000010

// File: files.f
design/issue_pkg.sv
design/inst_rom.sv
design/steer_unit.sv
design/issue_ctrl.sv
design/issue_regs.sv
design/dual_issue_top.sv
sim/dual_issue_assert.sv
sim/tb_dual_issue.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator and run from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_dual_issue \
  -o sim_dual_issue > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_dual_issue > sim.log 2>&1
status=$?
cat sim.log
grep -q "Test failed" sim.log && exit 1
[ "$status" -eq 0 ] && grep -q "Test completed successfully" sim.log || exit 1
exit 0
